/* dv/clk_gen.sv */
// testbench clock and power-on reset
module clk_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic CLK,
    output logic nRST
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;     // 4 ns period
    end

    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;               // released away from the active edge
    end

endmodule

/* dv/mem_model.sv */
// behavioural memory with fixed busy latency and a log of completed transfers
module mem_model import cache_pkg::*; #(
    parameter int LATENCY = 2
) (
    input  logic     CLK,
    input  word_t    mem_addr,
    input  word_t    mem_wdata,
    input  logic     mem_ren,
    input  logic     mem_wen,
    input  byte_en_t mem_byte_en,
    output word_t    mem_rdata,
    output logic     mem_busy
);
    timeunit 1ns;
    timeprecision 100ps;

    word_t    store [word_t];   // written words, by word address
    word_t    log_addr [$];
    word_t    log_data [$];
    logic     log_write [$];
    byte_en_t log_be [$];
    int       wait_cnt = 0;
    word_t    merged;

    // unwritten words hold a pattern of their whole address
    function automatic word_t preload(word_t a);
        return a ^ {a[7:0], a[31:8]} ^ 32'h5A3C_96E1;
    endfunction

    function automatic word_t read_word(word_t a);
        word_t wa;
        wa = {a[31:2], 2'b00};
        if (store.exists(wa))
            return store[wa];
        return preload(wa);
    endfunction

    initial mem_rdata = '0;

    assign mem_busy = wait_cnt != LATENCY;

    always @(posedge CLK) begin
        if (mem_ren || mem_wen) begin
            if (wait_cnt == LATENCY) begin
                wait_cnt <= 0;      // transfer completes in this cycle
                log_addr.push_back(mem_addr);
                log_write.push_back(mem_wen);
                log_be.push_back(mem_byte_en);
                if (mem_wen) begin
                    merged = read_word(mem_addr);
                    for (int i = 0; i < WORD_BYTES; i++) begin
                        if (mem_byte_en[i])
                            merged[8*i +: 8] = mem_wdata[8*i +: 8];
                    end
                    store[{mem_addr[31:2], 2'b00}] = merged;
                    log_data.push_back(mem_wdata);
                end else begin
                    log_data.push_back(mem_rdata);
                end
            end else begin
                if (wait_cnt == LATENCY - 1)
                    mem_rdata <= read_word(mem_addr);   // valid in the completing cycle
                wait_cnt <= wait_cnt + 1;
            end
        end else begin
            wait_cnt <= 0;
        end
    end

endmodule

/* dv/tb_l1_cache.sv */
// testbench top with directed cache tests, shadow memory, watchdog and summary
module tb_l1_cache import cache_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CACHE_BYTES    = 1024;
    localparam int BLOCK_WORDS    = 2;
    localparam int LINE_BYTES     = BLOCK_WORDS * WORD_BYTES;
    localparam int N_SETS         = CACHE_BYTES / LINE_BYTES;
    localparam int MEM_LATENCY    = 2;
    localparam int N_ACCESSES     = 330;
    localparam int ACCESS_CYCLES  = 2 * BLOCK_WORDS * (MEM_LATENCY + 1) + 4;  // wb plus fill
    localparam int FLUSH_CYCLES   = N_SETS * BLOCK_WORDS * (MEM_LATENCY + 1) + 8;
    localparam int TIMEOUT_CYCLES = 4 * (N_ACCESSES * ACCESS_CYCLES + FLUSH_CYCLES);

    logic CLK, nRST, flush, flush_done, ren, wen, busy;
    logic mem_ren, mem_wen, mem_busy;
    word_t addr, wdata, rdata, mem_addr, mem_wdata, mem_rdata;
    byte_en_t byte_en, mem_byte_en;

    word_t        shadow [word_t];     // expected contents by word address
    logic [15:0]  lfsr = 16'd64442;
    int           checks = 0;
    int           errors = 0;
    cache_state_t stuck_state;

    clk_gen #(.RESET_CYCLES(8)) clocks (.CLK, .nRST);

    l1_cache dut (
        .CLK, .nRST, .flush, .flush_done, .ren, .wen, .addr, .wdata, .byte_en, .rdata, .busy,
        .mem_addr, .mem_wdata, .mem_ren, .mem_wen, .mem_byte_en, .mem_rdata, .mem_busy
    );

    mem_model #(.LATENCY(MEM_LATENCY)) mem (
        .CLK, .mem_addr, .mem_wdata, .mem_ren, .mem_wen, .mem_byte_en, .mem_rdata, .mem_busy
    );

    // galois lfsr stepped once per bit
    function automatic word_t rand_bits(int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic word_t mem_pattern(word_t a);
        return a ^ {a[7:0], a[31:8]} ^ 32'h5A3C_96E1;
    endfunction

    function automatic word_t shadow_read(word_t a);
        if (shadow.exists(a))
            return shadow[a];
        return mem_pattern(a);
    endfunction

    function automatic void shadow_write(word_t a, word_t d, byte_en_t be);
        word_t w;
        w = shadow_read(a);
        for (int i = 0; i < WORD_BYTES; i++) begin
            if (be[i])
                w[8*i +: 8] = d[8*i +: 8];
        end
        shadow[a] = w;
    endfunction

    function automatic int log_size();
        return mem.log_addr.size();
    endfunction

    task automatic check_value(string name, word_t exp, word_t got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, got);
        end
    endtask

    task automatic check_true(logic ok, string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("Error: %s", what);
        end
    endtask

    // one core access held until busy drops
    task automatic access(input logic wr, input word_t a, input word_t d, input byte_en_t be,
                          output word_t rd);
        @(posedge CLK);
        ren     <= !wr;
        wen     <= wr;
        addr    <= a;
        wdata   <= d;
        byte_en <= be;
        @(negedge CLK);
        while (busy) @(negedge CLK);
        rd = rdata;
        @(posedge CLK);
        ren <= 1'b0;
        wen <= 1'b0;
        if (wr)
            shadow_write(a, d, be);
        @(negedge CLK);     // completing transfer is in the memory log by now
    endtask

    task automatic read_check(string name, word_t a);
        word_t rd;
        access(1'b0, a, '0, '0, rd);
        check_value(name, shadow_read(a), rd);
    endtask

    task automatic store_bytes(word_t a, word_t d, byte_en_t be);
        word_t rd;
        access(1'b1, a, d, be, rd);
    endtask

    task automatic expect_log(string name, int idx, word_t a, logic wr);
        check_value(name, a, mem.log_addr[idx]);
        check_true(mem.log_write[idx] === wr, $sformatf("%s: wrong direction at %h", name, a));
    endtask

    task automatic read_miss_then_hit();
        int n0;
        n0 = log_size();
        read_check("read miss then hit", 32'h0000_1230);
        check_value("read miss then hit", BLOCK_WORDS, word_t'(log_size() - n0));
        for (int i = 0; i < BLOCK_WORDS; i++)
            expect_log("read miss then hit", n0 + i, 32'h0000_1230 + 4 * i, 1'b0);
        n0 = log_size();
        read_check("read miss then hit", 32'h0000_1234);
        check_true(log_size() == n0, "read hit caused a memory transfer");
    endtask

    task automatic write_hit_byte_lanes();
        byte_en_t lanes [3] = '{4'b0001, 4'b0011, 4'b1100};
        word_t    datas [3] = '{32'h1111_11A5, 32'h2222_B6C7, 32'hD8E9_3333};
        int       n0;
        n0 = log_size();
        for (int i = 0; i < 3; i++) begin
            store_bytes(32'h0000_1230, datas[i], lanes[i]);
            read_check("write hit byte lanes", 32'h0000_1230);
        end
        check_true(log_size() == n0, "write hit reached memory");
    endtask

    task automatic dirty_eviction();
        int n0;
        n0 = log_size();
        read_check("dirty eviction", 32'h0000_1630);   // same set and next tag
        check_value("dirty eviction", 2 * BLOCK_WORDS, word_t'(log_size() - n0));
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            expect_log("dirty eviction", n0 + i, 32'h0000_1230 + 4 * i, 1'b1);
            check_value("dirty eviction", shadow_read(32'h0000_1230 + 4 * i),
                        mem.log_data[n0 + i]);
            expect_log("dirty eviction", n0 + BLOCK_WORDS + i, 32'h0000_1630 + 4 * i, 1'b0);
        end
    endtask

    task automatic pass_through_access();
        int n0;
        n0 = log_size();
        store_bytes(32'h8000_0040, 32'hDEAD_BEEF, 4'b0110);
        check_true(log_size() == n0 + 1, "pass-through write did not reach memory once");
        expect_log("pass-through", n0, 32'h8000_0040, 1'b1);
        check_value("pass-through", 32'h00AD_BE00, mem.log_data[n0]);
        check_value("pass-through", 32'h0000_0006, word_t'(mem.log_be[n0]));
        for (int i = 0; i < 2; i++) begin
            read_check("pass-through", 32'h8000_0040);
            expect_log("pass-through", n0 + 1 + i, 32'h8000_0040, 1'b0);
        end
    endtask

    task automatic flush_all_lines();
        word_t    addrs [4] = '{32'h0000_2000, 32'h0000_200C, 32'h0000_2010, 32'h0000_201C};
        byte_en_t lanes [4] = '{4'b1111, 4'b0101, 4'b1000, 4'b0011};
        int       n0, pulses, cycles, found;
        word_t    last;
        foreach (addrs[i])
            store_bytes(addrs[i], rand_bits(32), lanes[i]);
        n0 = log_size();
        @(posedge CLK);
        flush <= 1'b1;
        @(posedge CLK);
        flush <= 1'b0;
        pulses = 0;
        cycles = 0;
        while (cycles < FLUSH_CYCLES && (pulses == 0 || cycles < 4)) begin
            @(negedge CLK);
            if (pulses > 0)
                cycles++;           // a few cycles after the pulse
            else if (flush_done)
                cycles = 0;
            else
                cycles++;
            if (flush_done)
                pulses++;
        end
        check_true(pulses == 1, $sformatf("flush_done pulsed %0d times, not once", pulses));
        foreach (addrs[i]) begin
            found = 0;
            last  = '0;
            for (int k = n0; k < log_size(); k++) begin
                if (mem.log_write[k] && mem.log_addr[k] == addrs[i]) begin
                    found = 1;
                    last  = mem.log_data[k];
                end
            end
            check_true(found == 1, $sformatf("no write-back of %h during flush", addrs[i]));
            check_value("flush", shadow_read(addrs[i]), last);
        end
        n0 = log_size();
        read_check("flush", 32'h0000_2000);
        check_true(log_size() == n0 + BLOCK_WORDS, "read after flush was not a line fill");
        expect_log("flush", n0, 32'h0000_2000, 1'b0);
    endtask

    task automatic random_mix();
        word_t r, a, d;
        for (int n = 0; n < 300; n++) begin
            r = rand_bits(6);
            a = {r[5], 19'h0, r[4:3], 5'h0, r[2:1], r[0], 2'b00};
            r = rand_bits(1);
            if (r[0]) begin
                r = rand_bits(4);
                d = rand_bits(32);
                store_bytes(a, d, r[3:0]);
            end else begin
                read_check("random mix", a);
            end
        end
    endtask

    initial begin
        ren     = 1'b0;
        wen     = 1'b0;
        addr    = '0;
        wdata   = '0;
        byte_en = '0;
        flush   = 1'b0;
        @(posedge nRST);
        read_miss_then_hit();
        write_hit_byte_lanes();
        dirty_eviction();
        pass_through_access();
        flush_all_lines();
        random_mix();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK);
        stuck_state = dut.u_ctrl.state;
        $display("timeout after %0d cycles in state %s, checks %0d, errors %0d",
                 TIMEOUT_CYCLES, stuck_state.name(), checks, errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the L1 cache testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_l1_cache -Mdir obj_dir -o sim_l1_cache -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_l1_cache)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

/* sim.f */
verilog/cache_pkg.sv
verilog/cache_array.sv
verilog/hit_check.sv
verilog/line_counter.sv
verilog/cache_ctrl.sv
verilog/l1_cache.sv
dv/clk_gen.sv
dv/mem_model.sv
dv/tb_l1_cache.sv

/* verilog/cache_array.sv */
// line storage: tags, valid and dirty bits, data words with byte-lane writes
module cache_array import cache_pkg::*; #(
    parameter int CACHE_BYTES = 1024,
    parameter int BLOCK_WORDS = 2,
    localparam int N_SETS        = CACHE_BYTES / (WORD_BYTES * BLOCK_WORDS),
    localparam int SET_BITS      = $clog2(N_SETS),
    localparam int WORD_SEL_BITS = $clog2(BLOCK_WORDS) + (BLOCK_WORDS == 1),
    localparam int TAG_BITS      = 32 - SET_BITS - WORD_SEL_BITS - BYTE_OFFSET_BITS
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic [SET_BITS-1:0]      set_sel,
    input  logic [WORD_SEL_BITS-1:0] word_sel,
    output logic [TAG_BITS-1:0]      rd_tag,
    output logic                     rd_valid,
    output logic                     rd_dirty,
    output word_t                    rd_word,
    input  word_t                    wr_data,
    input  byte_en_t                 wr_byte_en,
    input  logic                     write_word,
    input  logic                     mark_dirty,
    input  logic                     fill_done,
    input  logic                     clean_line,
    input  logic                     invalidate,
    input  logic [TAG_BITS-1:0]      fill_tag
);

    logic [TAG_BITS-1:0] tag_mem [N_SETS];
    word_t               data_mem [N_SETS][BLOCK_WORDS];
    logic [N_SETS-1:0]   valid_bits;
    logic [N_SETS-1:0]   dirty_bits;

    // asynchronous read port
    assign rd_tag   = tag_mem[set_sel];
    assign rd_valid = valid_bits[set_sel];
    assign rd_dirty = dirty_bits[set_sel];
    assign rd_word  = data_mem[set_sel][word_sel];

    // data and tag writes, lane by lane
    always_ff @(posedge CLK) begin
        if (write_word) begin
            for (int i = 0; i < WORD_BYTES; i++) begin
                if (wr_byte_en[i])
                    data_mem[set_sel][word_sel][8*i +: 8] <= wr_data[8*i +: 8];
            end
        end
        if (fill_done)
            tag_mem[set_sel] <= fill_tag;   // tag lands with the last fill word
    end

    // line status updates
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (invalidate) begin
            valid_bits[set_sel] <= 1'b0;
            dirty_bits[set_sel] <= 1'b0;
        end else if (fill_done) begin
            valid_bits[set_sel] <= 1'b1;
            dirty_bits[set_sel] <= 1'b0;
        end else if (clean_line) begin
            dirty_bits[set_sel] <= 1'b0;    // victim written back
        end else if (mark_dirty) begin
            dirty_bits[set_sel] <= 1'b1;
        end
    end

endmodule

/* verilog/cache_ctrl.sv */
// cache controller FSM: core bus, memory bus, array updates and counter control
module cache_ctrl import cache_pkg::*; #(
    parameter int CACHE_BYTES = 1024,
    parameter int BLOCK_WORDS = 2,
    localparam int N_SETS        = CACHE_BYTES / (WORD_BYTES * BLOCK_WORDS),
    localparam int SET_BITS      = $clog2(N_SETS),
    localparam int WORD_SEL_BITS = $clog2(BLOCK_WORDS) + (BLOCK_WORDS == 1),
    localparam int TAG_BITS      = 32 - SET_BITS - WORD_SEL_BITS - BYTE_OFFSET_BITS
) (
    input  logic                     CLK,
    input  logic                     nRST,
    // core bus
    input  logic                     ren,
    input  logic                     wen,
    input  word_t                    addr,
    input  word_t                    wdata,
    input  byte_en_t                 byte_en,
    output word_t                    rdata,
    output logic                     busy,
    input  logic                     flush,
    output logic                     flush_done,
    // memory bus
    output word_t                    mem_addr,
    output word_t                    mem_wdata,
    output logic                     mem_ren,
    output logic                     mem_wen,
    output byte_en_t                 mem_byte_en,
    input  word_t                    mem_rdata,
    input  logic                     mem_busy,
    // hit check
    input  logic                     hit,
    input  logic                     pass_through,
    input  logic [SET_BITS-1:0]      req_set,
    input  logic [WORD_SEL_BITS-1:0] req_word,
    input  logic [TAG_BITS-1:0]      req_tag,
    // array
    input  logic [TAG_BITS-1:0]      rd_tag,
    input  logic                     rd_valid,
    input  logic                     rd_dirty,
    input  word_t                    rd_word,
    output logic [SET_BITS-1:0]      set_sel,
    output logic [WORD_SEL_BITS-1:0] word_sel,
    output logic [TAG_BITS-1:0]      fill_tag,
    output word_t                    wr_data,
    output byte_en_t                 wr_byte_en,
    output logic                     write_word,
    output logic                     mark_dirty,
    output logic                     fill_done,
    output logic                     clean_line,
    output logic                     invalidate,
    // counters
    output logic                     word_en,
    output logic                     word_clr,
    output logic                     flush_word_en,
    output logic                     flush_line_skip,
    output logic                     flush_clr,
    input  logic [WORD_SEL_BITS-1:0] word_idx,
    input  logic [SET_BITS-1:0]      flush_set,
    input  logic [WORD_SEL_BITS-1:0] flush_word,
    input  logic                     last_word,
    input  logic                     flush_end
);

    localparam logic [WORD_SEL_BITS-1:0] LAST_WORD = WORD_SEL_BITS'(BLOCK_WORDS - 1);

    cache_state_t state, next_state;
    logic         flush_req;      // flush seen outside HIT
    word_t        lane_data;      // pass-through write data, unused lanes zeroed

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= HIT;
            flush_req <= 1'b0;
        end else begin
            state <= next_state;
            if (state == HIT)
                flush_req <= 1'b0;  // HIT takes the flush itself
            else if (flush)
                flush_req <= 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < WORD_BYTES; i++)
            lane_data[8*i +: 8] = byte_en[i] ? wdata[8*i +: 8] : 8'h00;
    end

    // array addressing
    assign set_sel  = (state == FLUSH) ? flush_set : req_set;
    assign word_sel = (state == FLUSH) ? flush_word :
                      (state == HIT)   ? req_word   : word_idx;
    assign fill_tag   = req_tag;
    assign wr_data    = (state == FETCH) ? mem_rdata : wdata;
    assign wr_byte_en = (state == FETCH) ? '1 : byte_en;

    always_comb begin
        next_state      = state;
        busy            = ren | wen;    // high while a request waits
        rdata           = rd_word;
        mem_addr        = '0;
        mem_wdata       = '0;
        mem_ren         = 1'b0;
        mem_wen         = 1'b0;
        mem_byte_en     = '1;           // full words for fills and evictions
        write_word      = 1'b0;
        mark_dirty      = 1'b0;
        fill_done       = 1'b0;
        clean_line      = 1'b0;
        invalidate      = 1'b0;
        word_en         = 1'b0;
        word_clr        = 1'b0;
        flush_word_en   = 1'b0;
        flush_line_skip = 1'b0;
        flush_clr       = 1'b0;
        flush_done      = 1'b0;

        case (state)
            HIT: begin
                word_clr  = 1'b1;
                flush_clr = 1'b1;
                if (flush || flush_req) begin
                    next_state = FLUSH;     // pending request waits for the flush
                end else if ((ren || wen) && pass_through) begin
                    mem_ren     = ren;
                    mem_wen     = wen;
                    mem_addr    = addr;
                    mem_wdata   = lane_data;
                    mem_byte_en = byte_en;
                    busy        = mem_busy;
                    rdata       = mem_rdata;
                end else if ((ren || wen) && hit) begin
                    busy       = 1'b0;
                    write_word = wen;
                    mark_dirty = wen;
                end else if (ren || wen) begin
                    next_state = (rd_valid && rd_dirty) ? WB : FETCH;
                end
            end
            WB: begin
                // victim tag still in the array until the fill
                mem_wen   = 1'b1;
                mem_addr  = {rd_tag, req_set, word_idx, {BYTE_OFFSET_BITS{1'b0}}};
                mem_wdata = rd_word;
                if (!mem_busy) begin
                    word_en = 1'b1;
                    if (last_word) begin
                        clean_line = 1'b1;
                        word_clr   = 1'b1;
                        next_state = FETCH;
                    end
                end
            end
            FETCH: begin
                mem_ren  = 1'b1;
                mem_addr = {req_tag, req_set, word_idx, {BYTE_OFFSET_BITS{1'b0}}};
                if (!mem_busy) begin
                    write_word = 1'b1;
                    word_en    = 1'b1;
                    if (last_word) begin
                        fill_done  = 1'b1;  // tag and valid with the last word
                        word_clr   = 1'b1;
                        next_state = HIT;
                    end
                end
            end
            FLUSH: begin
                if (flush_end) begin
                    flush_done = 1'b1;
                    next_state = HIT;
                end else if (rd_valid && rd_dirty) begin
                    mem_wen   = 1'b1;
                    mem_addr  = {rd_tag, flush_set, flush_word, {BYTE_OFFSET_BITS{1'b0}}};
                    mem_wdata = rd_word;
                    if (!mem_busy) begin
                        flush_word_en = 1'b1;
                        invalidate    = flush_word == LAST_WORD;
                    end
                end else begin
                    // clean or invalid line, one cycle
                    invalidate      = 1'b1;
                    flush_line_skip = 1'b1;
                end
            end
            default: next_state = HIT;
        endcase
    end

endmodule

/* verilog/cache_pkg.sv */
// shared bus types, byte enables, address constants and controller state type
package cache_pkg;

    // bus word geometry
    localparam int WORD_BITS        = 32;
    localparam int WORD_BYTES       = WORD_BITS / 8;
    localparam int BYTE_OFFSET_BITS = $clog2(WORD_BYTES);

    // one bus word, used for addresses and data
    typedef logic [WORD_BITS-1:0] word_t;

    // bit i enables byte i of a word
    typedef logic [WORD_BYTES-1:0] byte_en_t;

    // controller states
    // only one request is in flight at a time
    typedef enum logic [1:0] {
        HIT,    // serve hits, pass-through and take flush requests
        FETCH,  // line fill from memory
        WB,     // dirty victim written back before the fill
        FLUSH   // walk every set, write back and invalidate
    } cache_state_t;

endpackage

/* verilog/hit_check.sv */
// address split into tag, set and word, tag compare, hit and pass-through flags
module hit_check import cache_pkg::*; #(
    parameter int    CACHE_BYTES    = 1024,
    parameter int    BLOCK_WORDS    = 2,
    parameter word_t NONCACHE_START = 32'h8000_0000,
    localparam int N_SETS        = CACHE_BYTES / (WORD_BYTES * BLOCK_WORDS),
    localparam int SET_BITS      = $clog2(N_SETS),
    localparam int WORD_SEL_BITS = $clog2(BLOCK_WORDS) + (BLOCK_WORDS == 1),
    localparam int TAG_BITS      = 32 - SET_BITS - WORD_SEL_BITS - BYTE_OFFSET_BITS
) (
    input  word_t                    addr,
    input  logic [TAG_BITS-1:0]      rd_tag,
    input  logic                     rd_valid,
    output logic [SET_BITS-1:0]      req_set,
    output logic [WORD_SEL_BITS-1:0] req_word,
    output logic [TAG_BITS-1:0]      req_tag,
    output logic                     hit,
    output logic                     pass_through
);

    localparam int WORD_LSB = BYTE_OFFSET_BITS;
    localparam int SET_LSB  = BYTE_OFFSET_BITS + WORD_SEL_BITS;

    // address layout: tag | set | word | byte
    assign req_tag  = addr[31 -: TAG_BITS];
    assign req_set  = addr[SET_LSB +: SET_BITS];
    assign req_word = addr[WORD_LSB +: WORD_SEL_BITS];

    // everything from the window start upward bypasses the cache
    assign pass_through = addr >= NONCACHE_START;

    // stored line belongs to this address
    assign hit = rd_valid && (rd_tag == req_tag) && !pass_through;

endmodule

/* verilog/l1_cache.sv */
// direct-mapped write-back L1 data cache top level
module l1_cache import cache_pkg::*; #(
    parameter int    CACHE_BYTES    = 1024,
    parameter int    BLOCK_WORDS    = 2,
    parameter word_t NONCACHE_START = 32'h8000_0000
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     flush,
    output logic     flush_done,
    // core bus
    input  logic     ren,
    input  logic     wen,
    input  word_t    addr,
    input  word_t    wdata,
    input  byte_en_t byte_en,
    output word_t    rdata,
    output logic     busy,
    // memory bus
    output word_t    mem_addr,
    output word_t    mem_wdata,
    output logic     mem_ren,
    output logic     mem_wen,
    output byte_en_t mem_byte_en,
    input  word_t    mem_rdata,
    input  logic     mem_busy
);

    localparam int N_SETS        = CACHE_BYTES / (WORD_BYTES * BLOCK_WORDS);
    localparam int SET_BITS      = $clog2(N_SETS);
    localparam int WORD_SEL_BITS = $clog2(BLOCK_WORDS) + (BLOCK_WORDS == 1);
    localparam int TAG_BITS      = 32 - SET_BITS - WORD_SEL_BITS - BYTE_OFFSET_BITS;

    logic                     hit, pass_through;
    logic [SET_BITS-1:0]      req_set, set_sel, flush_set;
    logic [WORD_SEL_BITS-1:0] req_word, word_sel, word_idx, flush_word;
    logic [TAG_BITS-1:0]      req_tag, rd_tag, fill_tag;
    logic                     rd_valid, rd_dirty;
    word_t                    rd_word, wr_data;
    byte_en_t                 wr_byte_en;
    logic                     write_word, mark_dirty, fill_done, clean_line, invalidate;
    logic                     word_en, word_clr, last_word;
    logic                     flush_word_en, flush_line_skip, flush_clr, flush_end;

    cache_ctrl #(.CACHE_BYTES(CACHE_BYTES), .BLOCK_WORDS(BLOCK_WORDS)) u_ctrl (
        .CLK, .nRST, .ren, .wen, .addr, .wdata, .byte_en, .rdata, .busy,
        .flush, .flush_done,
        .mem_addr, .mem_wdata, .mem_ren, .mem_wen, .mem_byte_en, .mem_rdata, .mem_busy,
        .hit, .pass_through, .req_set, .req_word, .req_tag,
        .rd_tag, .rd_valid, .rd_dirty, .rd_word,
        .set_sel, .word_sel, .fill_tag, .wr_data, .wr_byte_en,
        .write_word, .mark_dirty, .fill_done, .clean_line, .invalidate,
        .word_en, .word_clr, .flush_word_en, .flush_line_skip, .flush_clr,
        .word_idx, .flush_set, .flush_word, .last_word, .flush_end
    );

    cache_array #(.CACHE_BYTES(CACHE_BYTES), .BLOCK_WORDS(BLOCK_WORDS)) u_array (
        .CLK, .nRST, .set_sel, .word_sel, .rd_tag, .rd_valid, .rd_dirty, .rd_word,
        .wr_data, .wr_byte_en, .write_word, .mark_dirty, .fill_done, .clean_line,
        .invalidate, .fill_tag
    );

    hit_check #(
        .CACHE_BYTES(CACHE_BYTES),
        .BLOCK_WORDS(BLOCK_WORDS),
        .NONCACHE_START(NONCACHE_START)
    ) u_hit (
        .addr, .rd_tag, .rd_valid, .req_set, .req_word, .req_tag, .hit, .pass_through
    );

    line_counter #(.BLOCK_WORDS(BLOCK_WORDS), .CACHE_BYTES(CACHE_BYTES)) u_count (
        .CLK, .nRST, .word_en, .word_clr, .word_idx, .last_word,
        .flush_word_en, .flush_line_skip, .flush_clr, .flush_set, .flush_word, .flush_end
    );

endmodule

/* verilog/line_counter.sv */
// word counter for fills and write-backs, set and word walker for flush
module line_counter import cache_pkg::*; #(
    parameter int BLOCK_WORDS = 2,
    parameter int CACHE_BYTES = 1024,
    localparam int N_SETS        = CACHE_BYTES / (WORD_BYTES * BLOCK_WORDS),
    localparam int SET_BITS      = $clog2(N_SETS),
    localparam int WORD_SEL_BITS = $clog2(BLOCK_WORDS) + (BLOCK_WORDS == 1)
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     word_en,
    input  logic                     word_clr,
    output logic [WORD_SEL_BITS-1:0] word_idx,
    output logic                     last_word,
    input  logic                     flush_word_en,
    input  logic                     flush_line_skip,
    input  logic                     flush_clr,
    output logic [SET_BITS-1:0]      flush_set,
    output logic [WORD_SEL_BITS-1:0] flush_word,
    output logic                     flush_end
);

    localparam logic [WORD_SEL_BITS-1:0] LAST_WORD = WORD_SEL_BITS'(BLOCK_WORDS - 1);

    logic [SET_BITS:0] flush_pos;   // extra msb set once the walk passes the last set

    // word counter, one step per memory completion
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            word_idx <= '0;
        else if (word_clr)
            word_idx <= '0;
        else if (word_en)
            word_idx <= word_idx + 1'b1;
    end

    assign last_word = word_idx == LAST_WORD;

    // flush walker, by word or by whole line
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            flush_pos  <= '0;
            flush_word <= '0;
        end else if (flush_clr) begin
            flush_pos  <= '0;
            flush_word <= '0;
        end else if (flush_line_skip) begin
            flush_pos  <= flush_pos + 1'b1;
            flush_word <= '0;
        end else if (flush_word_en) begin
            if (flush_word == LAST_WORD) begin
                flush_pos  <= flush_pos + 1'b1;
                flush_word <= '0;
            end else begin
                flush_word <= flush_word + 1'b1;
            end
        end
    end

    assign flush_set = flush_pos[SET_BITS-1:0];
    assign flush_end = flush_pos[SET_BITS];

endmodule
